/* design/mul_data_pkg.sv */
package mul_data_pkg;

    // ------------------------------------------------------------------
    // Data path widths.
    // ------------------------------------------------------------------

    localparam int OPERAND_WIDTH = 64;
    localparam int SLICE_WIDTH   = 32;
    localparam int PARTIAL_WIDTH = OPERAND_WIDTH + SLICE_WIDTH;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // Multiplicand or multiplier.
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // One slice of the multiplier.
    typedef logic [SLICE_WIDTH-1:0] slice_t;

    // Operand times one slice.
    typedef logic [PARTIAL_WIDTH-1:0] partial_t;

    // Full product.
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // ------------------------------------------------------------------
    // Operands of one lane, a in the upper half.
    // ------------------------------------------------------------------

    typedef struct packed
    {
        operand_t a;
        operand_t b;
    } lane_operands_t;

endpackage

/* design/mul_ctrl_pkg.sv */
package mul_ctrl_pkg;

    // ------------------------------------------------------------------
    // Sequencer states.
    // ------------------------------------------------------------------

    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        SLICE = 2'd1,
        SUM   = 2'd2,
        ACK   = 2'd3
    } seq_state_t;

    // ------------------------------------------------------------------
    // Multiplier slice walk.
    // ------------------------------------------------------------------

    // Two slices per operand, low first.
    localparam int NUM_SLICES = 2;

    // 0 selects the low slice, 1 the high slice.
    typedef logic [0:0] slice_idx_t;

endpackage

/* design/mul_sequencer.sv */
`timescale 1ns/1ns

module mul_sequencer
(
    input  logic clk_in,
    input  logic reset_in,
    input  logic req,
    input  logic last,
    output logic load,
    output logic step,
    output logic clear,
    output logic advance,
    output logic ack
);

    import mul_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       ack_next;

    // ------------------------------------------------------------------
    // Next state and strobes.
    // ------------------------------------------------------------------

    always_comb
    begin
        state_next = state;
        ack_next   = ack;
        load       = 1'b0;
        clear      = 1'b0;
        step       = 1'b0;
        advance    = 1'b0;

        case (state)
            IDLE:
            begin
                // Operands are captured on the edge that sees req.
                if (req)
                begin
                    load       = 1'b1;
                    clear      = 1'b1;
                    state_next = SLICE;
                end
            end

            SLICE:
            begin
                step    = 1'b1;
                advance = 1'b1;
                if (last)
                begin
                    state_next = SUM;
                end
            end

            // Adder tree registers the sum on this edge.
            SUM:
            begin
                state_next = ACK;
            end

            ACK:
            begin
                if (!ack)
                begin
                    ack_next = 1'b1;
                end
                else if (!req)
                begin
                    ack_next   = 1'b0;
                    state_next = IDLE;
                end
            end

            default:
            begin
                state_next = IDLE;
                ack_next   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= IDLE;
            ack   <= 1'b0;
        end
        else
        begin
            state <= state_next;
            ack   <= ack_next;
        end
    end

endmodule

/* design/slice_counter.sv */
`timescale 1ns/1ns

module slice_counter
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     clear,
    input  logic                     advance,
    output mul_ctrl_pkg::slice_idx_t slice_idx,
    output logic                     last
);

    import mul_ctrl_pkg::*;

    // Clear wins over advance.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            slice_idx <= '0;
        end
        else if (clear)
        begin
            slice_idx <= '0;
        end
        else if (advance)
        begin
            slice_idx <= slice_idx + 1'b1;
        end
    end

    // High slice is the final step.
    assign last = (slice_idx == slice_idx_t'(NUM_SLICES - 1));

endmodule

/* design/partial_product_unit.sv */
`timescale 1ns/1ns

module partial_product_unit
#(
    parameter int NUM_LANES = 2
)
(
    input  logic                                             clk_in,
    input  logic                                             reset_in,
    input  logic                                             load,
    input  logic                                             step,
    input  mul_ctrl_pkg::slice_idx_t                         slice_idx,
    input  mul_data_pkg::lane_operands_t                     operands [NUM_LANES],
    output logic [NUM_LANES*mul_data_pkg::PARTIAL_WIDTH-1:0] operand_package_1,
    output logic [NUM_LANES*mul_data_pkg::PARTIAL_WIDTH-1:0] operand_package_2
);

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    genvar lane;

    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : g_lane
            operand_t a_reg;
            operand_t b_reg;
            slice_t   b_slice;
            partial_t lane_partial;
            partial_t partial_lo;
            partial_t partial_hi;

            // ----------------------------------------------------------
            // Operand capture.
            // ----------------------------------------------------------

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    a_reg <= '0;
                    b_reg <= '0;
                end
                else if (load)
                begin
                    a_reg <= operands[lane].a;
                    b_reg <= operands[lane].b;
                end
            end

            // ----------------------------------------------------------
            // 64 x 32 multiply on the selected slice.
            // ----------------------------------------------------------

            assign b_slice      = b_reg[slice_idx * SLICE_WIDTH +: SLICE_WIDTH];
            assign lane_partial = partial_t'(a_reg) * partial_t'(b_slice);

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    partial_lo <= '0;
                    partial_hi <= '0;
                end
                else if (step)
                begin
                    if (slice_idx == slice_idx_t'(0))
                    begin
                        partial_lo <= lane_partial;
                    end
                    else
                    begin
                        partial_hi <= lane_partial;
                    end
                end
            end

            // Lane 0 sits in the most significant field.
            assign operand_package_1[(NUM_LANES-1-lane)*PARTIAL_WIDTH +: PARTIAL_WIDTH] =
                partial_hi;
            assign operand_package_2[(NUM_LANES-1-lane)*PARTIAL_WIDTH +: PARTIAL_WIDTH] =
                partial_lo;
        end
    endgenerate

endmodule

/* design/adder_tree.sv */
`timescale 1ns/1ns

module adder_tree
#(
    parameter int NUM_ADDER = 2
)
(
    input  logic                                             clk_in,
    input  logic                                             reset_in,
    input  logic [NUM_ADDER*mul_data_pkg::PARTIAL_WIDTH-1:0] operand_package_1,
    input  logic [NUM_ADDER*mul_data_pkg::PARTIAL_WIDTH-1:0] operand_package_2,
    output logic [NUM_ADDER*mul_data_pkg::PRODUCT_WIDTH-1:0] result_package
);

    import mul_data_pkg::*;

    localparam int OPERAND_PACKAGE_SIZE = NUM_ADDER * PARTIAL_WIDTH;
    localparam int RESULT_PACKAGE_SIZE  = NUM_ADDER * PRODUCT_WIDTH;

    genvar gen;

    generate
        for (gen = 0; gen < NUM_ADDER; gen++)
        begin : g_adder
            localparam int OP_LO  = OPERAND_PACKAGE_SIZE - (gen + 1) * PARTIAL_WIDTH;
            localparam int RES_LO = RESULT_PACKAGE_SIZE - (gen + 1) * PRODUCT_WIDTH;

            product_t gen_operand_1;
            product_t gen_operand_2;

            // High partial moves up one slice, low partial stays put.
            assign gen_operand_1 = {operand_package_1[OP_LO +: PARTIAL_WIDTH],
                                    {SLICE_WIDTH{1'b0}}};
            assign gen_operand_2 = {{SLICE_WIDTH{1'b0}},
                                    operand_package_2[OP_LO +: PARTIAL_WIDTH]};

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    result_package[RES_LO +: PRODUCT_WIDTH] <= '0;
                end
                else
                begin
                    result_package[RES_LO +: PRODUCT_WIDTH] <= gen_operand_1 + gen_operand_2;
                end
            end
        end
    endgenerate

endmodule

/* design/wide_mul_top.sv */
`timescale 1ns/1ns

module wide_mul_top
#(
    parameter int NUM_LANES = 2
)
(
    input  logic                         clk_in,
    input  logic                         reset_in,
    input  logic                         req,
    input  mul_data_pkg::lane_operands_t operands [NUM_LANES],
    output logic                         ack,
    output mul_data_pkg::product_t       products [NUM_LANES]
);

    import mul_data_pkg::*;
    import mul_ctrl_pkg::*;

    logic                               load;
    logic                               step;
    logic                               clear;
    logic                               advance;
    logic                               last;
    slice_idx_t                         slice_idx;
    logic [NUM_LANES*PARTIAL_WIDTH-1:0] operand_package_1;
    logic [NUM_LANES*PARTIAL_WIDTH-1:0] operand_package_2;
    logic [NUM_LANES*PRODUCT_WIDTH-1:0] result_package;

    // ------------------------------------------------------------------
    // Control.
    // ------------------------------------------------------------------

    mul_sequencer mul_sequencer_inst
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .req      (req),
        .last     (last),
        .load     (load),
        .step     (step),
        .clear    (clear),
        .advance  (advance),
        .ack      (ack)
    );

    slice_counter slice_counter_inst
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .clear     (clear),
        .advance   (advance),
        .slice_idx (slice_idx),
        .last      (last)
    );

    // ------------------------------------------------------------------
    // Data path.
    // ------------------------------------------------------------------

    partial_product_unit #(.NUM_LANES(NUM_LANES)) partial_product_unit_inst
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .load              (load),
        .step              (step),
        .slice_idx         (slice_idx),
        .operands          (operands),
        .operand_package_1 (operand_package_1),
        .operand_package_2 (operand_package_2)
    );

    adder_tree #(.NUM_ADDER(NUM_LANES)) adder_tree_inst
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .operand_package_1 (operand_package_1),
        .operand_package_2 (operand_package_2),
        .result_package    (result_package)
    );

    // Lane 0 comes from the top field.
    genvar lane;

    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : g_unpack
            assign products[lane] =
                result_package[(NUM_LANES-1-lane)*PRODUCT_WIDTH +: PRODUCT_WIDTH];
        end
    endgenerate

endmodule

/* dv/wide_mul_tb.sv */
`timescale 1ns/1ns

module wide_mul_tb;

    import mul_data_pkg::*;

    localparam int NUM_LANES   = 2;
    localparam int NUM_FIXED   = 10;
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_ROWS    = NUM_FIXED + NUM_RANDOM;
    localparam int ACK_LATENCY = 4;
    localparam int WAIT_LIMIT  = 50;

    localparam operand_t ONES = '1;

    logic           clk_in;
    logic           reset_in;
    logic           req;
    lane_operands_t operands [NUM_LANES];
    logic           ack;
    product_t       products [NUM_LANES];

    lane_operands_t stim_table [NUM_ROWS][NUM_LANES];
    product_t       expected   [NUM_ROWS][NUM_LANES];
    int             value_errors;
    int             protocol_errors;
    bit             timed_out;

    wide_mul_top #(.NUM_LANES(NUM_LANES)) wide_mul_top_inst
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .req      (req),
        .operands (operands),
        .ack      (ack),
        .products (products)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // ------------------------------------------------------------------
    // Stimulus table.
    // ------------------------------------------------------------------

    task automatic set_row(input int row, input operand_t a0, input operand_t b0,
                           input operand_t a1, input operand_t b1);
        stim_table[row][0] = '{a: a0, b: b0};
        stim_table[row][1] = '{a: a1, b: b1};
    endtask

    task automatic fill_table();
        set_row(0, 64'd0, 64'd0, 64'd0, ONES);
        set_row(1, 64'd1, 64'd1, 64'd1, 64'h0123_4567_89AB_CDEF);
        set_row(2, ONES, ONES, ONES, ONES);
        // Rows 3 to 5, 7 and 8 change only one lane.
        set_row(3, 64'hFFFF_FFFF_0000_0000, 64'h8000_0000_0000_0000, ONES, ONES);
        set_row(4, 64'hFFFF_FFFF_0000_0000, 64'h8000_0000_0000_0000,
                64'h0000_0000_FFFF_FFFF, 64'h0000_0000_1234_5678);
        set_row(5, 64'h0000_0000_8765_4321, 64'h0000_0000_FFFF_FFFF,
                64'h0000_0000_FFFF_FFFF, 64'h0000_0000_1234_5678);
        set_row(6, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210,
                64'hDEAD_BEEF_CAFE_F00D, 64'h0000_0001_0000_0001);
        set_row(7, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210,
                64'hAAAA_AAAA_5555_5555, 64'h5555_5555_AAAA_AAAA);
        set_row(8, 64'hFFFF_FFFF_0000_0001, 64'h0000_0001_FFFF_FFFF,
                64'hAAAA_AAAA_5555_5555, 64'h5555_5555_AAAA_AAAA);
        set_row(9, ONES, 64'd1, 64'h8000_0000_0000_0000, 64'd2);

        for (int row = NUM_FIXED; row < NUM_ROWS; row++)
        begin
            set_row(row, {$urandom, $urandom}, {$urandom, $urandom},
                    {$urandom, $urandom}, {$urandom, $urandom});
        end

        // Unsigned 128-bit reference products.
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            for (int lane = 0; lane < NUM_LANES; lane++)
            begin
                expected[row][lane] = product_t'(stim_table[row][lane].a) *
                                      product_t'(stim_table[row][lane].b);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------

    task automatic check_products(input int row);
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            assert (products[lane] == expected[row][lane])
            else
            begin
                value_errors++;
                $display("[FAIL] %0t ns products[%0d] row %0d expected %h actual %h",
                         $time, lane, row, expected[row][lane], products[lane]);
            end
        end
    endtask

    // A lane whose operands repeat the previous row keeps its product throughout.
    task automatic check_unchanged_lanes(input int row);
        if (row > 0)
        begin
            for (int lane = 0; lane < NUM_LANES; lane++)
            begin
                if (stim_table[row][lane] == stim_table[row-1][lane])
                begin
                    assert (products[lane] == expected[row-1][lane])
                    else
                    begin
                        value_errors++;
                        $display("[FAIL] %0t ns products[%0d] row %0d expected %h actual %h",
                                 $time, lane, row, expected[row-1][lane], products[lane]);
                    end
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Handshake helpers.
    // ------------------------------------------------------------------

    task automatic wait_for_ack(input int row, output int cycles);
        cycles = 0;
        while (!timed_out)
        begin
            @(posedge clk_in);
            cycles++;
            @(negedge clk_in);
            check_unchanged_lanes(row);
            if (ack)
            begin
                break;
            end
            if (cycles >= WAIT_LIMIT)
            begin
                protocol_errors++;
                timed_out = 1'b1;
                $display("Timeout: ack did not rise within %0d cycles on row %0d",
                         WAIT_LIMIT, row);
            end
        end
    endtask

    task automatic wait_for_ack_low(input int row, output int cycles);
        cycles = 0;
        while (!timed_out)
        begin
            @(posedge clk_in);
            cycles++;
            @(negedge clk_in);
            if (!ack)
            begin
                break;
            end
            if (cycles >= WAIT_LIMIT)
            begin
                protocol_errors++;
                timed_out = 1'b1;
                $display("Timeout: ack stayed high %0d cycles after req dropped on row %0d",
                         WAIT_LIMIT, row);
            end
        end
    endtask

    task automatic run_row(input int row);
        int cycles;
        int extra;

        @(posedge clk_in);
        req <= 1'b1;
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            operands[lane] <= stim_table[row][lane];
        end

        // Sampling edge. Operands are free to change after it.
        @(posedge clk_in);
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            operands[lane] <= {$urandom, $urandom, $urandom, $urandom};
        end

        wait_for_ack(row, cycles);
        if (timed_out)
        begin
            return;
        end
        assert (cycles == ACK_LATENCY)
        else
        begin
            protocol_errors++;
            $display("[FAIL] %0t ns ack latency row %0d expected %0d actual %0d",
                     $time, row, ACK_LATENCY, cycles);
        end
        check_products(row);

        extra = $urandom_range(0, 10);
        repeat (extra)
        begin
            @(posedge clk_in);
            @(negedge clk_in);
            assert (ack == 1'b1)
            else
            begin
                protocol_errors++;
                $display("[FAIL] %0t ns ack row %0d expected 1 actual %b", $time, row, ack);
            end
            check_products(row);
        end

        @(posedge clk_in);
        req <= 1'b0;
        wait_for_ack_low(row, cycles);
        if (!timed_out)
        begin
            // Ack drops on the first edge that sees req low.
            assert (cycles == 1)
            else
            begin
                protocol_errors++;
                $display("[FAIL] %0t ns ack fall latency row %0d expected 1 actual %0d",
                         $time, row, cycles);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------

    initial
    begin
        void'($urandom(55));
        reset_in        = 1'b1;
        req             = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        timed_out       = 1'b0;
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            operands[lane] = '0;
        end

        fill_table();

        repeat (16) @(posedge clk_in);
        reset_in <= 1'b0;

        // Idle with req low.
        repeat (8)
        begin
            @(negedge clk_in);
            assert (ack == 1'b0)
            else
            begin
                protocol_errors++;
                $display("[FAIL] %0t ns ack after reset expected 0 actual %b", $time, ack);
            end
        end

        for (int row = 0; row < NUM_ROWS; row++)
        begin
            run_row(row);
            if (timed_out)
            begin
                break;
            end
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
design/mul_data_pkg.sv
design/mul_ctrl_pkg.sv
design/mul_sequencer.sv
design/slice_counter.sv
design/partial_product_unit.sv
design/adder_tree.sv
design/wide_mul_top.sv
dv/wide_mul_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module wide_mul_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vwide_mul_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
